// ==== filelist.f ====
+incdir+design
design/cache_pkg.sv
design/cache_way_if.sv
design/cache_way.sv
design/way_select.sv
design/cache_ctrl.sv
design/main_mem.sv
design/mem_system.sv
verif/mem_system_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module mem_system_tb -o mem_system_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_system_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi

echo "Pass line not found in sim.log"
exit 1

// ==== verif/mem_system_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module mem_system_tb;
    import cache_pkg::*;

    localparam int NUM_DIRECTED = 18;
    localparam int NUM_RANDOM   = 40;
    localparam int REQ_LIMIT    = 20;
    localparam int MEM_WORDS    = 2**(`ADDR_W-1);
    // Longest request is 12 cycles, two more to drive it
    localparam int TIMEOUT_CYCLES = 8 + (NUM_DIRECTED + NUM_RANDOM) * (12 + 2) + 100;

    // Latency classes
    localparam logic [1:0] LAT_HIT   = 2'd0;
    localparam logic [1:0] LAT_CLEAN = 2'd1;
    localparam logic [1:0] LAT_DIRTY = 2'd2;

    typedef struct packed {
        logic       is_st;
        addr_t      addr;
        word_t      data;
        logic       exp_hit;
        logic [1:0] exp_class;
        logic       from_table;
    } entry_t;

    logic  clk;
    logic  rst_n;
    logic  ld;
    logic  st;
    addr_t addr;
    word_t data_in;
    word_t data_out;
    logic  done;
    logic  stall;
    logic  cache_hit;

    entry_t tests[$];
    word_t  ref_mem   [MEM_WORDS];
    logic   ref_valid [2][`NUM_SETS];
    logic   ref_dirty [2][`NUM_SETS];
    tag_t   ref_tag   [2][`NUM_SETS];
    logic   ref_flip;
    integer seed = 32'hbba3_1b61;
    int     errors;
    int     cycle_count;

    mem_system mem_system_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld        (ld),
        .st        (st),
        .addr      (addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_entry(input logic is_st, input addr_t a, input word_t d,
                             input logic exp_hit, input logic [1:0] exp_class,
                             input logic from_table);
        entry_t e;
        e.is_st      = is_st;
        e.addr       = a;
        e.data       = d;
        e.exp_hit    = exp_hit;
        e.exp_class  = exp_class;
        e.from_table = from_table;
        tests.push_back(e);
    endtask

    // Flat coherent memory plus tag state of both ways
    task automatic model_access(input entry_t e, output logic m_hit,
                                output logic [1:0] m_class, output word_t m_data);
        tag_t   t;
        index_t idx;
        logic   way;
        t     = e.addr[15:11];
        idx   = e.addr[10:3];
        m_hit = 1'b0;
        way   = 1'b0;
        if (ref_valid[0][idx] && (ref_tag[0][idx] == t)) begin
            m_hit = 1'b1;
        end else if (ref_valid[1][idx] && (ref_tag[1][idx] == t)) begin
            m_hit = 1'b1;
            way   = 1'b1;
        end
        if (m_hit) begin
            m_class = LAT_HIT;
            if (e.is_st) begin
                ref_dirty[way][idx] = 1'b1;
            end
        end else begin
            // Invalid way first, then the flip bit
            if (!ref_valid[0][idx]) begin
                way = 1'b0;
            end else if (!ref_valid[1][idx]) begin
                way = 1'b1;
            end else begin
                way = ref_flip;
            end
            m_class = (ref_valid[way][idx] && ref_dirty[way][idx]) ? LAT_DIRTY : LAT_CLEAN;
            ref_valid[way][idx] = 1'b1;
            ref_dirty[way][idx] = 1'b0;
            ref_tag[way][idx]   = t;
        end
        if (e.is_st) begin
            ref_mem[e.addr[15:1]] = e.data;
        end
        m_data   = ref_mem[e.addr[15:1]];
        ref_flip = ~ref_flip;
    endtask

    function automatic int done_cycle_for(input logic [1:0] lat, input addr_t a);
        int w;
        w = int'(a[2:1]);
        case (lat)
            LAT_HIT: return 1;
            LAT_CLEAN: return 4 + w;
            default: return 8 + w;
        endcase
    endfunction

    function automatic int idle_cycle_for(input logic [1:0] lat);
        case (lat)
            LAT_HIT: return 2;
            LAT_CLEAN: return 8;
            default: return 12;
        endcase
    endfunction

    task automatic run_request(input int num, input entry_t e);
        logic       m_hit;
        logic [1:0] m_class;
        word_t      m_data;
        logic       exp_hit;
        logic [1:0] exp_class;
        int         exp_done;
        int         exp_idle;
        int         done_at;
        int         idle_at;
        int         done_count;
        int         cyc;
        int         errs_before;
        logic       stray_hit;
        logic       got_hit;
        word_t      got_data;
        errs_before = errors;
        model_access(e, m_hit, m_class, m_data);
        exp_hit   = e.from_table ? e.exp_hit : m_hit;
        exp_class = e.from_table ? e.exp_class : m_class;
        exp_done  = done_cycle_for(exp_class, e.addr);
        exp_idle  = idle_cycle_for(exp_class);

        @(posedge clk);
        ld      <= ~e.is_st;
        st      <= e.is_st;
        addr    <= e.addr;
        data_in <= e.data;
        @(negedge clk);
        assert (!stall) else begin
            $display("test %0d: cache still stalled when the request was issued", num);
            errors++;
        end
        // Acceptance edge
        @(posedge clk);
        ld <= 1'b0;
        st <= 1'b0;

        done_at    = 0;
        idle_at    = 0;
        done_count = 0;
        cyc        = 0;
        stray_hit  = 1'b0;
        got_hit    = 1'b0;
        got_data   = '0;
        while ((idle_at == 0) && (cyc < REQ_LIMIT)) begin
            cyc++;
            @(negedge clk);
            if (done) begin
                done_count++;
                if (done_at == 0) begin
                    done_at  = cyc;
                    got_hit  = cache_hit;
                    got_data = data_out;
                end
            end else if (cache_hit) begin
                stray_hit = 1'b1;
            end
            if (!stall) begin
                idle_at = cyc;
            end
        end

        assert (idle_at != 0) else begin
            $display("test %0d: stall stayed high for %0d cycles", num, REQ_LIMIT);
            errors++;
        end
        assert (done_count == 1) else begin
            $display("test %0d: done pulsed %0d times instead of once", num, done_count);
            errors++;
        end
        assert (!stray_hit) else begin
            $display("test %0d: cache_hit was high without done", num);
            errors++;
        end
        if (done_at != 0) begin
            assert (done_at == exp_done) else begin
                $display("test %0d: done came in cycle %0d instead of cycle %0d",
                         num, done_at, exp_done);
                errors++;
            end
            assert (got_hit == exp_hit) else begin
                $display("[ERROR] test %0d: cache_hit = %h, expected %h", num, got_hit, exp_hit);
                errors++;
            end
            if (!e.is_st) begin
                assert (got_data == m_data) else begin
                    $display("[ERROR] test %0d: data_out = %h, expected %h",
                             num, got_data, m_data);
                    errors++;
                end
            end
        end
        if (idle_at != 0) begin
            assert (idle_at == exp_idle) else begin
                $display("test %0d: back in idle in cycle %0d instead of cycle %0d",
                         num, idle_at, exp_idle);
                errors++;
            end
        end
        $display("test %0d %s %h: done in cycle %0d, %s", num, e.is_st ? "st" : "ld",
                 e.addr, done_at, (errors == errs_before) ? "ok" : "FAIL");
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int          i;
        logic [31:0] r;
        index_t      rand_index;
        ld       = 1'b0;
        st       = 1'b0;
        addr     = '0;
        data_in  = '0;
        rst_n    = 1'b0;
        errors   = 0;
        ref_flip = 1'b0;
        for (i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i[14:0]] = word_t'(i * 2) ^ `MEM_INIT_PATTERN;
        end
        for (i = 0; i < `NUM_SETS; i++) begin
            ref_valid[0][i[7:0]] = 1'b0;
            ref_valid[1][i[7:0]] = 1'b0;
            ref_dirty[0][i[7:0]] = 1'b0;
            ref_dirty[1][i[7:0]] = 1'b0;
        end

        // Set 5 holds tags 1, 2 and 3, set 9 takes a store miss
        add_entry(1'b0, 16'h082c, 16'h0000, 1'b0, LAT_CLEAN, 1'b1);
        add_entry(1'b0, 16'h082c, 16'h0000, 1'b1, LAT_HIT, 1'b1);
        add_entry(1'b1, 16'h082a, 16'hbeef, 1'b1, LAT_HIT, 1'b1);
        add_entry(1'b0, 16'h082a, 16'h0000, 1'b1, LAT_HIT, 1'b1);
        add_entry(1'b0, 16'h1028, 16'h0000, 1'b0, LAT_CLEAN, 1'b1);
        add_entry(1'b0, 16'h182e, 16'h0000, 1'b0, LAT_CLEAN, 1'b1);
        add_entry(1'b0, 16'h1028, 16'h0000, 1'b0, LAT_DIRTY, 1'b1);
        add_entry(1'b0, 16'h082a, 16'h0000, 1'b0, LAT_CLEAN, 1'b1);
        add_entry(1'b1, 16'h204a, 16'h1234, 1'b0, LAT_CLEAN, 1'b1);
        add_entry(1'b0, 16'h2048, 16'h0000, 1'b1, LAT_HIT, 1'b1);
        add_entry(1'b0, 16'h204c, 16'h0000, 1'b1, LAT_HIT, 1'b1);
        add_entry(1'b0, 16'h204a, 16'h0000, 1'b1, LAT_HIT, 1'b1);
        add_entry(1'b1, 16'h182e, 16'h7777, 1'b0, LAT_CLEAN, 1'b1);
        add_entry(1'b0, 16'h182e, 16'h0000, 1'b1, LAT_HIT, 1'b1);

        // Clean line of the store miss leaves set 9, the reload comes from memory
        add_entry(1'b0, 16'h2848, 16'h0000, 1'b0, LAT_CLEAN, 1'b1);
        add_entry(1'b0, 16'h3048, 16'h0000, 1'b0, LAT_CLEAN, 1'b1);
        add_entry(1'b0, 16'h3848, 16'h0000, 1'b0, LAT_CLEAN, 1'b1);
        add_entry(1'b0, 16'h204a, 16'h0000, 1'b0, LAT_CLEAN, 1'b1);

        // Eight tags over three sets so conflicts are frequent
        for (i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            case (r[4:3])
                2'd0: rand_index = 8'd5;
                2'd1: rand_index = 8'd9;
                2'd2: rand_index = 8'd12;
                default: rand_index = 8'd5;
            endcase
            add_entry(r[7], {2'b00, r[2:0], rand_index, r[6:5], 1'b0}, r[23:8],
                      1'b0, LAT_HIT, 1'b0);
        end

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!stall && !done && !cache_hit) else begin
            $display("[ERROR] after reset: stall = %h, done = %h, cache_hit = %h, expected 0",
                     stall, done, cache_hit);
            errors++;
        end

        for (i = 0; i < tests.size(); i++) begin
            run_request(i, tests[i]);
        end

        $display("%0d tests run, %0d errors", tests.size(), errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/mem_system.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_system (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ld,
    input  logic        st,
    input  logic [15:0] addr,
    input  logic [15:0] data_in,
    output logic [15:0] data_out,
    output logic        done,
    output logic        stall,
    output logic        cache_hit
);
    import cache_pkg::*;

    logic  hit;
    logic  hit_way;
    logic  victim_way;
    logic  victim_dirty;
    logic  flip;
    logic  rd;
    logic  wr;
    tag_t  victim_tag;
    word_t hit_data;
    word_t victim_data;
    addr_t mem_addr;
    word_t mem_data;
    word_t data_mem;

    cache_way_if way0_if ();
    cache_way_if way1_if ();

    cache_way way0_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (way0_if)
    );

    cache_way way1_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (way1_if)
    );

    way_select way_select_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .way0         (way0_if),
        .way1         (way1_if),
        .flip         (flip),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .hit_data     (hit_data),
        .victim_data  (victim_data)
    );

    cache_ctrl cache_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .ld           (ld),
        .st           (st),
        .addr         (addr),
        .data_in      (data_in),
        .way0         (way0_if),
        .way1         (way1_if),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .hit_data     (hit_data),
        .victim_data  (victim_data),
        .flip         (flip),
        .rd           (rd),
        .wr           (wr),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .data_mem     (data_mem),
        .data_out     (data_out),
        .done         (done),
        .stall        (stall),
        .cache_hit    (cache_hit)
    );

    main_mem main_mem_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd       (rd),
        .wr       (wr),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .data_mem (data_mem)
    );

endmodule

`default_nettype wire

// ==== design/main_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module main_mem (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rd,
    input  logic             wr,
    input  cache_pkg::addr_t mem_addr,
    input  cache_pkg::word_t mem_data,
    output cache_pkg::word_t data_mem
);
    import cache_pkg::*;

    word_t              mem [2**(`ADDR_W-1)];
    logic [`ADDR_W-2:0] word_addr;
    logic [`ADDR_W-2:0] rd_addr_q;
    logic               rd_pend_q;

    // Word addressed, byte offset bit 0 dropped
    assign word_addr = mem_addr[`ADDR_W-1:1];

    // Each word starts as its byte address scrambled by the pattern
    initial begin
        for (int i = 0; i < 2**(`ADDR_W-1); i++) begin
            mem[i] = word_t'(i << 1) ^ `MEM_INIT_PATTERN;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[word_addr] <= mem_data;
        end
    end

    // Stage 1 holds the address, stage 2 the data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= rd;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            rd_addr_q <= word_addr;
        end
        if (rd_pend_q) begin
            data_mem <= mem[rd_addr_q];
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ld,
    input  logic             st,
    input  cache_pkg::addr_t addr,
    input  cache_pkg::word_t data_in,
    cache_way_if.ctrl        way0,
    cache_way_if.ctrl        way1,
    input  logic             hit,
    input  logic             hit_way,
    input  logic             victim_way,
    input  cache_pkg::tag_t  victim_tag,
    input  logic             victim_dirty,
    input  cache_pkg::word_t hit_data,
    input  cache_pkg::word_t victim_data,
    output logic             flip,
    output logic             rd,
    output logic             wr,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::word_t mem_data,
    input  cache_pkg::word_t data_mem,
    output cache_pkg::word_t data_out,
    output logic             done,
    output logic             stall,
    output logic             cache_hit
);
    import cache_pkg::*;

    ctrl_state_e          state;
    ctrl_state_e          next_state;
    addr_t                addr_q;
    word_t                data_q;
    logic                 st_q;
    logic                 way_q;
    tag_t                 vtag_q;
    word_t                data_out_q;
    tag_t                 req_tag;
    index_t               req_index;
    offset_t              req_offset;
    logic [`OFFSET_W-2:0] req_word;
    logic [`OFFSET_W-2:0] mem_word;
    logic [`OFFSET_W-2:0] fill_word;
    logic                 in_cmp;
    logic                 in_evict;
    logic                 in_alloc;
    logic                 in_fill;
    logic                 en0;
    logic                 en1;
    logic                 cmp;
    logic                 way_write;
    offset_t              offset_sel;
    word_t                cache_data;
    word_t                done_data;

    assign req_tag    = addr_q[`ADDR_W-1 -: `TAG_W];
    assign req_index  = addr_q[`OFFSET_W +: `INDEX_W];
    assign req_offset = addr_q[`OFFSET_W-1:0];
    assign req_word   = req_offset[`OFFSET_W-1:1];

    assign in_cmp   = (state == CMP_RD) || (state == CMP_WR);
    assign in_evict = state inside {EVICT0, EVICT1, EVICT2, EVICT3};
    assign in_alloc = state inside {ALLOC0, ALLOC1, ALLOC2, ALLOC3};
    assign in_fill  = state inside {ALLOC2, ALLOC3, AW0, AW1};

    // Word on the memory port, and word being filled two cycles behind it
    always_comb begin
        mem_word  = 2'd0;
        fill_word = 2'd0;
        case (state)
            EVICT1, ALLOC1: mem_word = 2'd1;
            EVICT2: mem_word = 2'd2;
            EVICT3: mem_word = 2'd3;
            ALLOC2: begin
                mem_word  = 2'd2;
                fill_word = 2'd0;
            end
            ALLOC3: begin
                mem_word  = 2'd3;
                fill_word = 2'd1;
            end
            AW0: fill_word = 2'd2;
            AW1: fill_word = 2'd3;
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (ld) begin
                    next_state = CMP_RD;
                end else if (st) begin
                    next_state = CMP_WR;
                end
            end
            CMP_RD, CMP_WR: begin
                if (hit) begin
                    next_state = IDLE;
                end else if (victim_dirty) begin
                    next_state = EVICT0;
                end else begin
                    next_state = ALLOC0;
                end
            end
            EVICT0: next_state = EVICT1;
            EVICT1: next_state = EVICT2;
            EVICT2: next_state = EVICT3;
            EVICT3: next_state = ALLOC0;
            ALLOC0: next_state = ALLOC1;
            ALLOC1: next_state = ALLOC2;
            ALLOC2: next_state = ALLOC3;
            ALLOC3: next_state = AW0;
            AW0: next_state = AW1;
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        en0        = 1'b0;
        en1        = 1'b0;
        cmp        = 1'b0;
        way_write  = 1'b0;
        offset_sel = req_offset;
        cache_data = data_q;
        rd         = 1'b0;
        wr         = 1'b0;
        mem_addr   = {req_tag, req_index, mem_word, 1'b0};
        mem_data   = data_q;
        done       = 1'b0;
        done_data  = hit_data;

        // Probe both ways, a store hit writes in place
        if (in_cmp) begin
            en0       = 1'b1;
            en1       = 1'b1;
            cmp       = 1'b1;
            way_write = st_q;
            done      = hit;
        end

        // Drain the victim line word by word
        if (in_evict) begin
            en0        = ~way_q;
            en1        = way_q;
            offset_sel = {mem_word, 1'b0};
            wr         = 1'b1;
            mem_addr   = {vtag_q, req_index, mem_word, 1'b0};
            mem_data   = victim_data;
        end

        // Store miss writes its own word through instead of reading it
        if (in_alloc) begin
            if (st_q && (mem_word == req_word)) begin
                wr = 1'b1;
            end else begin
                rd = 1'b1;
            end
        end

        if (in_fill) begin
            en0        = ~way_q;
            en1        = way_q;
            way_write  = 1'b1;
            offset_sel = {fill_word, 1'b0};
            if (st_q && (fill_word == req_word)) begin
                cache_data = data_q;
            end else begin
                cache_data = data_mem;
            end
            done      = (fill_word == req_word);
            done_data = cache_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && (ld || st)) begin
            addr_q <= addr;
            data_q <= data_in;
            st_q   <= ~ld;
        end
        // Way choice is fixed for the rest of the request
        if (in_cmp) begin
            way_q  <= hit ? hit_way : victim_way;
            vtag_q <= victim_tag;
        end
        if (done) begin
            data_out_q <= done_data;
        end
    end

    assign stall     = (state != IDLE);
    assign flip      = in_cmp;
    assign cache_hit = in_cmp & hit;
    assign data_out  = done ? done_data : data_out_q;

    assign way0.en        = en0;
    assign way0.cmp       = cmp;
    assign way0.write     = way_write;
    assign way0.valid_in  = 1'b1;
    assign way0.tag_in    = req_tag;
    assign way0.index_in  = req_index;
    assign way0.offset_in = offset_sel;
    assign way0.cache_in  = cache_data;

    assign way1.en        = en1;
    assign way1.cmp       = cmp;
    assign way1.write     = way_write;
    assign way1.valid_in  = 1'b1;
    assign way1.tag_in    = req_tag;
    assign way1.index_in  = req_index;
    assign way1.offset_in = offset_sel;
    assign way1.cache_in  = cache_data;

    assert property (@(posedge clk) disable iff (!rst_n) done |-> stall);
    assert property (@(posedge clk) disable iff (!rst_n) !(rd && wr));
    assert property (@(posedge clk) disable iff (!rst_n)
        (in_evict || in_alloc) |-> !(way0.en && way1.en));
    // Every read issued lands in a fill state
    assert property (@(posedge clk) disable iff (!rst_n)
        rd |-> ##(`MEM_RD_LATENCY) in_fill);

endmodule

`default_nettype wire

// ==== design/way_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module way_select (
    input  logic             clk,
    input  logic             rst_n,
    cache_way_if.mon         way0,
    cache_way_if.mon         way1,
    input  logic             flip,
    output logic             hit,
    output logic             hit_way,
    output logic             victim_way,
    output cache_pkg::tag_t  victim_tag,
    output logic             victim_dirty,
    output cache_pkg::word_t hit_data,
    output cache_pkg::word_t victim_data
);
    import cache_pkg::*;

    logic flip_q;
    logic data_way;

    // Tags in one set never repeat, so at most one way hits
    assign hit      = way0.hit | way1.hit;
    assign hit_way  = way1.hit;
    assign hit_data = way1.hit ? way1.data_out : way0.data_out;

    // Invalid way first, then the flip bit
    always_comb begin
        if (!way0.valid) begin
            victim_way = 1'b0;
        end else if (!way1.valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = flip_q;
        end
    end

    assign victim_tag   = victim_way ? way1.tag_out : way0.tag_out;
    assign victim_dirty = victim_way ? (way1.valid & way1.dirty)
                                     : (way0.valid & way0.dirty);

    // During eviction only the latched victim way is enabled
    always_comb begin
        if (way1.en && !way0.en) begin
            data_way = 1'b1;
        end else if (way0.en && !way1.en) begin
            data_way = 1'b0;
        end else begin
            data_way = victim_way;
        end
    end

    assign victim_data = data_way ? way1.data_out : way0.data_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flip_q <= 1'b0;
        end else if (flip) begin
            flip_q <= ~flip_q;
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_way.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_consts.svh"

module cache_way (
    input  logic     clk,
    input  logic     rst_n,
    cache_way_if.way bus
);
    import cache_pkg::*;

    logic [`NUM_SETS-1:0] valid_q;
    logic [`NUM_SETS-1:0] dirty_q;
    tag_t                 tag_q  [`NUM_SETS];
    word_t                line_q [`NUM_SETS][`WORDS_PER_LINE];
    logic [`OFFSET_W-2:0] word_sel;
    logic                 tag_match;
    logic                 do_write;

    // Bit 0 of the byte offset is always zero
    assign word_sel  = bus.offset_in[`OFFSET_W-1:1];
    assign tag_match = (tag_q[bus.index_in] == bus.tag_in);

    // Combinational lookup
    assign bus.valid    = valid_q[bus.index_in];
    assign bus.dirty    = dirty_q[bus.index_in];
    assign bus.tag_out  = tag_q[bus.index_in];
    assign bus.data_out = line_q[bus.index_in][word_sel];
    assign bus.hit      = bus.en & bus.cmp & bus.valid & tag_match;

    // Compare writes need a hit, fill writes always land
    assign do_write = bus.en & bus.write & (bus.hit | ~bus.cmp);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (do_write) begin
            // Store hit marks the line dirty, a fill leaves it clean
            dirty_q[bus.index_in] <= bus.cmp;
            if (!bus.cmp) begin
                valid_q[bus.index_in] <= bus.valid_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            line_q[bus.index_in][word_sel] <= bus.cache_in;
            if (!bus.cmp) begin
                tag_q[bus.index_in] <= bus.tag_in;
            end
        end
    end

    // A dirty line is always a valid one
    assert property (@(posedge clk) disable iff (!rst_n) bus.dirty |-> bus.valid);

endmodule

`default_nettype wire

// ==== design/cache_way_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface cache_way_if;
    import cache_pkg::*;

    // Requests from the controller
    logic    en;
    logic    cmp;
    logic    write;
    logic    valid_in;
    tag_t    tag_in;
    index_t  index_in;
    offset_t offset_in;
    word_t   cache_in;

    // Lookup results from the way
    word_t   data_out;
    tag_t    tag_out;
    logic    hit;
    logic    dirty;
    logic    valid;

    modport ctrl (
        output en, cmp, write, valid_in, tag_in, index_in, offset_in, cache_in
    );

    modport way (
        input  en, cmp, write, valid_in, tag_in, index_in, offset_in, cache_in,
        output data_out, tag_out, hit, dirty, valid
    );

    // Enable is visible so the selector knows which way is being drained
    modport mon (
        input en, data_out, tag_out, hit, dirty, valid
    );

endinterface

`default_nettype wire

// ==== design/cache_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

    // Byte address and data word
    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`DATA_W-1:0] word_t;

    // Address fields
    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`INDEX_W-1:0] index_t;
    typedef logic [`OFFSET_W-1:0] offset_t;

    // Controller FSM states
    typedef enum logic [3:0] {
        IDLE,
        CMP_RD,
        CMP_WR,
        EVICT0,
        EVICT1,
        EVICT2,
        EVICT3,
        ALLOC0,
        ALLOC1,
        ALLOC2,
        ALLOC3,
        AW0,
        AW1
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== design/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Processor side widths
`define ADDR_W 16
`define DATA_W 16

// Address split: tag | index | byte offset
`define TAG_W 5
`define INDEX_W 8
`define OFFSET_W 3

// Line geometry
`define NUM_SETS 256
`define WORDS_PER_LINE 4

// Backing memory
`define MEM_RD_LATENCY 2
`define MEM_INIT_PATTERN 16'h5a5a

`endif
